// File: filelist.f
cache_pkg.sv
cache_tag_lookup.sv
cache_refill_axi.sv
cache_line_store.sv
cache_front_ctrl.sv
cache_top.sv
tb_axi_mem.sv
tb_cache.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cache
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= tests failed
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_cache.sv
module tb_cache;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int ADDR_W     = 16;
   localparam int LINE2BE_W  = 2;
   localparam int N_REQ      = 55;      // 4 + 4 + 6 + 1 + 40 requests
   localparam int REFILL_MAX = 2 * 60;  // two bursts with stalls
   localparam int LIMIT      = N_REQ * (REFILL_MAX + 12) + 100;

   logic              clk_i;
   logic              reset;
   logic              req;
   logic [ADDR_W-1:0] addr;
   logic              ack;
   cache_pkg::word_t  rdata;
   logic [ADDR_W-1:0] araddr;
   logic [7:0]        arlen;
   logic              arvalid;
   logic              arready;
   cache_pkg::word_t  mem_rdata;
   cache_pkg::resp_t  rresp;
   logic              rlast;
   logic              rvalid;
   logic              rready;
   logic              stall_en;
   logic              inject_err;
   logic              expect_hit;
   integer            seed = 89876;
   int                cycle_count = 0;
   int                ar_count = 0;

   cache_top #(.ADDR_W(ADDR_W), .INDEX_W(3), .LINE2BE_W(LINE2BE_W)) uut (
      .clk_i(clk_i), .reset(reset), .req(req), .addr(addr), .ack(ack), .rdata(rdata),
      .axi_araddr(araddr), .axi_arlen(arlen), .axi_arvalid(arvalid), .axi_arready(arready),
      .axi_rdata(mem_rdata), .axi_rresp(rresp), .axi_rlast(rlast), .axi_rvalid(rvalid),
      .axi_rready(rready)
   );

   tb_axi_mem #(.ADDR_W(ADDR_W)) u_mem (
      .clk_i(clk_i), .reset(reset), .stall_en(stall_en), .inject_err(inject_err),
      .araddr(araddr), .arlen(arlen), .arvalid(arvalid), .arready(arready),
      .rdata(mem_rdata), .rresp(rresp), .rlast(rlast), .rvalid(rvalid), .rready(rready)
   );

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic check_word(input string test, input logic [31:0] expected,
                             input logic [31:0] actual);
      assert (actual === expected)
         else abort_run($sformatf("FAILED %s expected 0x%0h actual 0x%0h",
                                  test, expected, actual));
   endtask

   // backing word address xor pattern
   function automatic cache_pkg::word_t expected_word(input logic [ADDR_W-1:0] a);
      return 32'(a[ADDR_W-1:2]) ^ 32'h5A5A0000;
   endfunction

   // ar_expected below zero when the hit or miss is unknown
   task automatic read_word(input string test, input logic [ADDR_W-1:0] a, input int ar_expected);
      int ar_before;
      int edges;
      ar_before = ar_count;
      edges     = 0;
      req        <= 1'b1;
      addr       <= a;
      expect_hit <= (ar_expected == 0);
      do begin
         @(posedge clk_i);
         edges++;
      end while (!ack);
      check_word($sformatf("%s data", test), expected_word(a), rdata);
      if (ar_expected >= 0) begin
         check_word($sformatf("%s ar count", test), 32'(ar_expected), 32'(ar_count - ar_before));
      end
      if (ar_expected == 0) begin
         check_word($sformatf("%s hit latency", test), 32'd4, 32'(edges));  // sampled, set, seen
      end
      req <= 1'b0;
      do begin
         @(posedge clk_i);
      end while (ack);
      expect_hit <= 1'b0;
   endtask

   always @(posedge clk_i) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= LIMIT) begin
         abort_run("timeout, the cache stopped answering requests");
      end
      if (!reset && arvalid && arready) begin
         ar_count <= ar_count + 1;
         check_word("ar address",
                    32'({addr[ADDR_W-1:LINE2BE_W+2], {(LINE2BE_W+2){1'b0}}}), 32'(araddr));
         check_word("ar length", 32'(2**LINE2BE_W - 1), 32'(arlen));
      end
   end

   assert property (@(posedge clk_i) disable iff (reset) $rose(ack) |-> req)
      else abort_run("ack rose without a request");
   assert property (@(posedge clk_i) disable iff (reset) $fell(ack) |-> !$past(req))
      else abort_run("ack fell before req was dropped");
   assert property (@(posedge clk_i) disable iff (reset) ack && $past(ack) |-> $stable(rdata))
      else abort_run("rdata changed while ack was high");
   assert property (@(posedge clk_i) disable iff (reset)
                    arvalid && !arready |=> arvalid && $stable(araddr))
      else abort_run("arvalid or araddr changed before the request was accepted");
   assert property (@(posedge clk_i) disable iff (reset) expect_hit |-> !arvalid)
      else abort_run("arvalid raised on a cache hit");

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   initial begin
      reset      = 1'b1;
      req        = 1'b0;
      addr       = '0;
      stall_en   = 1'b0;
      inject_err = 1'b0;
      expect_hit = 1'b0;
      repeat (3) @(posedge clk_i);
      reset <= 1'b0;
      @(posedge clk_i);
      check_word("reset outputs", 32'd0, {29'b0, ack, arvalid, rready});
      for (int i = 0; i < 4; i++) begin
         read_word("first access", 16'(i * 16 + 4 * i), 1);  // lines 0 to 3
      end
      for (int i = 0; i < 4; i++) begin
         read_word("repeat hit", 16'(i * 16 + 4 * (3 - i)), 0);
      end
      for (int i = 0; i < 3; i++) begin
         read_word("same index a", 16'h0150, 1);  // index 5, tag 2
         read_word("same index b", 16'h0258, 1);  // index 5, tag 4
      end
      inject_err <= 1'b1;
      read_word("error retry", 16'h0364, 2);
      inject_err <= 1'b0;
      stall_en   <= 1'b1;
      for (int i = 0; i < 40; i++) begin
         read_word("random access", 16'($random(seed)), -1);
      end
      $display("all tests passed");
      $finish;
   end

endmodule

// File: tb_axi_mem.sv
module tb_axi_mem #(
   parameter int ADDR_W = 16
) (
   input  logic              clk_i,
   input  logic              reset,
   input  logic              stall_en,
   input  logic              inject_err,
   input  logic [ADDR_W-1:0] araddr,
   input  logic [7:0]        arlen,
   input  logic              arvalid,
   output logic              arready,
   output cache_pkg::word_t  rdata,
   output cache_pkg::resp_t  rresp,
   output logic              rlast,
   output logic              rvalid,
   input  logic              rready
);

   timeunit 1ns;
   timeprecision 1ps;

   localparam cache_pkg::word_t PATTERN  = 32'h5A5A0000;
   localparam cache_pkg::resp_t SLVERR   = 2'b10;
   localparam logic [7:0]       ERR_BEAT = 8'd1;  // second beat of the burst

   integer              seed = 89876;
   logic                busy;
   logic                inject_q;
   logic                err_pending;
   logic                burst_err;
   logic [ADDR_W-3:0]   base_word;
   logic [7:0]          len;
   logic [7:0]          beat_no;

   always @(posedge clk_i or posedge reset) begin
      if (reset) begin
         arready     <= 1'b0;
         rvalid      <= 1'b0;
         rlast       <= 1'b0;
         rdata       <= '0;
         rresp       <= '0;
         busy        <= 1'b0;
         inject_q    <= 1'b0;
         err_pending <= 1'b0;
         burst_err   <= 1'b0;
         base_word   <= '0;
         len         <= '0;
         beat_no     <= '0;
      end else begin
         inject_q <= inject_err;
         if (inject_err && !inject_q) begin
            err_pending <= 1'b1;  // armed for the next burst only
         end
         if (!busy) begin
            if (arvalid && arready) begin
               arready     <= 1'b0;
               busy        <= 1'b1;
               base_word   <= araddr[ADDR_W-1:2];
               len         <= arlen;
               beat_no     <= '0;
               burst_err   <= err_pending;
               err_pending <= 1'b0;
            end else begin
               arready <= arvalid && (!stall_en || (($random(seed) & 1) != 0));
            end
         end else if (!rvalid || rready) begin
            if (rvalid && rlast) begin
               busy   <= 1'b0;  // final beat taken
               rvalid <= 1'b0;
               rlast  <= 1'b0;
            end else if (stall_en && (($random(seed) & 3) == 0)) begin
               rvalid <= 1'b0;  // gap in the data stream
            end else begin
               rvalid  <= 1'b1;
               rdata   <= 32'(base_word + (ADDR_W-2)'(beat_no)) ^ PATTERN;
               rresp   <= (burst_err && beat_no == ERR_BEAT) ? SLVERR : 2'b00;
               rlast   <= (beat_no == len);
               beat_no <= beat_no + 8'd1;
            end
         end
      end
   end

endmodule

// File: cache_top.sv
module cache_top #(
   parameter int ADDR_W    = 16,
   parameter int INDEX_W   = 3,
   parameter int LINE2BE_W = 2
) (
   input  logic              clk_i,
   input  logic              reset,
   input  logic              req,
   input  logic [ADDR_W-1:0] addr,
   output logic              ack,
   output cache_pkg::word_t  rdata,
   output logic [ADDR_W-1:0] axi_araddr,
   output logic [7:0]        axi_arlen,
   output logic              axi_arvalid,
   input  logic              axi_arready,
   input  cache_pkg::word_t  axi_rdata,
   input  cache_pkg::resp_t  axi_rresp,
   input  logic              axi_rlast,
   input  logic              axi_rvalid,
   output logic              axi_rready
);

   localparam int LINE_W = ADDR_W - LINE2BE_W - 2;

   logic                 hit;
   logic                 tag_we;
   logic                 replace_valid;
   logic [LINE_W-1:0]    replace_addr;
   logic                 replace;
   logic                 read_valid;
   logic [LINE2BE_W-1:0] read_addr;
   cache_pkg::word_t     read_rdata;

   cache_tag_lookup #(.ADDR_W(ADDR_W), .INDEX_W(INDEX_W), .LINE2BE_W(LINE2BE_W)) u_lookup (
      .clk_i(clk_i), .reset(reset), .addr(addr), .tag_we(tag_we), .hit(hit)
   );

   cache_front_ctrl #(.ADDR_W(ADDR_W), .LINE2BE_W(LINE2BE_W)) u_ctrl (
      .clk_i(clk_i), .reset(reset), .req(req), .addr(addr), .ack(ack), .hit(hit),
      .replace_valid(replace_valid), .replace_addr(replace_addr), .replace(replace),
      .tag_we(tag_we)
   );

   cache_refill_axi #(.ADDR_W(ADDR_W), .LINE2BE_W(LINE2BE_W)) u_refill (
      .clk_i(clk_i), .reset(reset),
      .replace_valid(replace_valid), .replace_addr(replace_addr), .replace(replace),
      .read_valid(read_valid), .read_addr(read_addr), .read_rdata(read_rdata),
      .araddr(axi_araddr), .arlen(axi_arlen), .arvalid(axi_arvalid), .arready(axi_arready),
      .rdata(axi_rdata), .rresp(axi_rresp), .rlast(axi_rlast), .rvalid(axi_rvalid),
      .rready(axi_rready)
   );

   cache_line_store #(.ADDR_W(ADDR_W), .INDEX_W(INDEX_W), .LINE2BE_W(LINE2BE_W)) u_store (
      .clk_i(clk_i), .addr(addr), .read_valid(read_valid), .read_addr(read_addr),
      .read_rdata(read_rdata), .rdata(rdata)
   );

endmodule

// File: cache_front_ctrl.sv
module cache_front_ctrl #(
   parameter int ADDR_W    = 16,
   parameter int LINE2BE_W = 2
) (
   input  logic                        clk_i,
   input  logic                        reset,
   input  logic                        req,
   input  logic [ADDR_W-1:0]           addr,
   output logic                        ack,
   input  logic                        hit,
   output logic                        replace_valid,
   output logic [ADDR_W-LINE2BE_W-3:0] replace_addr,
   input  logic                        replace,
   output logic                        tag_we
);

   typedef enum logic [2:0] {
      idle,
      lookup,
      refill_start,
      refill_wait,
      tag_write,
      respond
   } front_state_t;

   front_state_t state;
   logic         req_q;

   assign replace_addr  = addr[ADDR_W-1:LINE2BE_W+2];  // tag and index
   assign replace_valid = (state == refill_start);
   assign tag_we        = (state == refill_wait) && !replace;  // refill just finished

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         state <= idle;
         req_q <= 1'b0;
         ack   <= 1'b0;
      end else begin
         req_q <= req;  // registered request
         case (state)
            idle: begin
               if (req_q) begin
                  state <= lookup;
               end
            end
            lookup: begin
               if (hit) begin
                  state <= respond;
                  ack   <= 1'b1;
               end else begin
                  state <= refill_start;
               end
            end
            refill_start: begin
               state <= refill_wait;
            end
            refill_wait: begin
               if (!replace) begin
                  state <= tag_write;
               end
            end
            tag_write: begin
               state <= lookup;  // hit flag picks up the new tag here
            end
            respond: begin
               if (!req_q) begin
                  state <= idle;
                  ack   <= 1'b0;
               end
            end
            default: begin
               state <= idle;
            end
         endcase
      end
   end

endmodule

// File: cache_line_store.sv
module cache_line_store #(
   parameter int ADDR_W    = 16,
   parameter int INDEX_W   = 3,
   parameter int LINE2BE_W = 2
) (
   input  logic                 clk_i,
   input  logic [ADDR_W-1:0]    addr,
   input  logic                 read_valid,
   input  logic [LINE2BE_W-1:0] read_addr,
   input  cache_pkg::word_t     read_rdata,
   output cache_pkg::word_t     rdata
);

   localparam int WORDS = 2**(INDEX_W + LINE2BE_W);

   typedef logic [INDEX_W+LINE2BE_W-1:0] word_addr_t;

   cache_pkg::word_t data_mem [WORDS];
   word_addr_t       wr_addr;
   word_addr_t       rd_addr;

   // index and word offset select one word of the whole store
   assign rd_addr = addr[2 +: INDEX_W+LINE2BE_W];
   assign wr_addr = {addr[LINE2BE_W+2 +: INDEX_W], read_addr};  // refill beat position

   always_ff @(posedge clk_i) begin
      if (read_valid) begin
         data_mem[wr_addr] <= read_rdata;
      end
      rdata <= data_mem[rd_addr];  // registered read, steady while addr is
   end

endmodule

// File: cache_refill_axi.sv
module cache_refill_axi #(
   parameter int ADDR_W    = 16,
   parameter int LINE2BE_W = 2
) (
   input  logic                          clk_i,
   input  logic                          reset,
   input  logic                          replace_valid,
   input  logic [ADDR_W-LINE2BE_W-3:0]   replace_addr,
   output logic                          replace,
   output logic                          read_valid,
   output logic [LINE2BE_W-1:0]          read_addr,
   output cache_pkg::word_t              read_rdata,
   output logic [ADDR_W-1:0]             araddr,
   output logic [7:0]                    arlen,
   output logic                          arvalid,
   input  logic                          arready,
   input  cache_pkg::word_t              rdata,
   input  cache_pkg::resp_t              rresp,
   input  logic                          rlast,
   input  logic                          rvalid,
   output logic                          rready
);

   localparam int LINE_W = ADDR_W - LINE2BE_W - 2;
   localparam cache_pkg::resp_t RESP_OKAY = 2'b00;

   typedef logic [LINE_W-1:0] line_addr_t;

   cache_pkg::refill_state_t state;
   line_addr_t               line_addr;
   logic                     slave_error;

   // line address is kept for the whole refill, retries included
   always_ff @(posedge clk_i) begin
      if (replace_valid && state == cache_pkg::idle) begin
         line_addr <= replace_addr;
      end
   end

   assign araddr     = {line_addr, {(LINE2BE_W+2){1'b0}}};  // line base, word aligned
   assign arlen      = 8'(2**LINE2BE_W - 1);                // one beat per line word
   assign read_valid = rvalid && rready;
   assign read_rdata = rdata;

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         state       <= cache_pkg::idle;
         read_addr   <= '0;
         slave_error <= 1'b0;
      end else begin
         case (state)
            cache_pkg::idle: begin
               read_addr   <= '0;
               slave_error <= 1'b0;
               if (replace_valid) begin
                  state <= cache_pkg::init_process;
               end
            end
            cache_pkg::init_process: begin
               read_addr   <= '0;
               slave_error <= 1'b0;  // fresh burst, forget the old error
               if (arready) begin
                  state <= cache_pkg::load_process;
               end
            end
            cache_pkg::load_process: begin
               if (rvalid) begin
                  if (rresp != RESP_OKAY) begin
                     slave_error <= 1'b1;  // burst runs to the end anyway
                  end
                  if (rlast) begin
                     state <= cache_pkg::end_process;  // counter stays on the last word
                  end else begin
                     read_addr <= read_addr + 1'b1;
                  end
               end
            end
            default: begin  // end_process
               if (slave_error) begin
                  state <= cache_pkg::init_process;
               end else begin
                  state <= cache_pkg::idle;
               end
            end
         endcase
      end
   end

   assign replace = (state != cache_pkg::idle);
   assign arvalid = (state == cache_pkg::init_process);
   assign rready  = (state == cache_pkg::load_process);

endmodule

// File: cache_tag_lookup.sv
module cache_tag_lookup #(
   parameter int ADDR_W    = 16,
   parameter int INDEX_W   = 3,
   parameter int LINE2BE_W = 2
) (
   input  logic              clk_i,
   input  logic              reset,
   input  logic [ADDR_W-1:0] addr,
   input  logic              tag_we,
   output logic              hit
);

   localparam int TAG_W = ADDR_W - INDEX_W - LINE2BE_W - 2;
   localparam int LINES = 2**INDEX_W;

   typedef logic [TAG_W-1:0]   tag_t;
   typedef logic [INDEX_W-1:0] index_t;

   tag_t             addr_tag;
   index_t           addr_index;
   tag_t             tag_mem [LINES];
   logic [LINES-1:0] valid;

   // byte address is tag | index | word offset | byte offset
   assign addr_tag   = addr[ADDR_W-1 -: TAG_W];
   assign addr_index = addr[LINE2BE_W+2 +: INDEX_W];

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         valid <= '0;
         hit   <= 1'b0;
      end else begin
         if (tag_we) begin
            valid[addr_index] <= 1'b1;  // line now holds refilled data
         end
         hit <= valid[addr_index] && (tag_mem[addr_index] == addr_tag);
      end
   end

   // tag store itself needs no clearing, valid bits qualify it
   always_ff @(posedge clk_i) begin
      if (tag_we) begin
         tag_mem[addr_index] <= addr_tag;
      end
   end

endmodule

// File: cache_pkg.sv
package cache_pkg;

   // front side and backing memory data word
   typedef logic [31:0] word_t;

   // axi read response code, okay is 2'b00
   typedef logic [1:0] resp_t;

   // refill channel sequencing, one burst per line
   typedef enum logic [1:0] {
      idle,          // no refill pending
      init_process,  // ar request on the bus
      load_process,  // collecting beats
      end_process    // burst done, retry if an error was seen
   } refill_state_t;

endpackage
